//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f src.f --top-module tb_logic_analyzer \
   -o tb_logic_analyzer > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_logic_analyzer > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" || {
   echo "simulation failed"
   exit 1
}

//--- src.f
src/la_pkg.sv
src/la_trigger_sampler.sv
src/la_capture_buffer.sv
src/la_host_port.sv
src/logic_analyzer.sv
verif/tb_logic_analyzer.sv

//--- src/la_capture_buffer.sv
module la_capture_buffer #(
   parameter int capture_depth = 32
) (
   input  logic                     observer_clk,
   input  logic                     reset,
   input  logic [3:0]               read_select,
   input  la_pkg::sample_t          sample,
   input  logic                     capture_go,
   output logic                     capturing,
   output logic [capture_depth-1:0] channel_word
);

   // Wide enough to hold capture_depth itself
   localparam int count_width = $clog2(capture_depth + 1);

   localparam logic [count_width-1:0] last_count = count_width'(capture_depth - 1);

   // Filler word sized to the capture depth
   localparam logic [capture_depth-1:0] bad_word =
      capture_depth'(la_pkg::bad_select_pattern);

   logic [capture_depth-1:0] shift_reg [la_pkg::num_channels];
   logic [count_width-1:0]   shift_count;

   // Load, shift and end of capture
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing   <= 1'b0;
         shift_count <= '0;
         for (int ch = 0; ch < la_pkg::num_channels; ch++) begin
            shift_reg[ch] <= '0;
         end
      end else if (capture_go) begin
         // New trigger also restarts a running capture
         capturing   <= 1'b1;
         shift_count <= '0;
         for (int ch = 0; ch < la_pkg::num_channels; ch++) begin
            shift_reg[ch] <= {sample[ch], {(capture_depth-1){1'b0}}};
         end
      end else if (capturing) begin
         for (int ch = 0; ch < la_pkg::num_channels; ch++) begin
            shift_reg[ch] <= {sample[ch], shift_reg[ch][capture_depth-1:1]};
         end
         if (shift_count < last_count) begin
            shift_count <= shift_count + 1'b1;
         end else begin
            capturing <= 1'b0;   // Last of capture_depth shifts
         end
      end
   end

   // Registered readback of the selected channel
   always_ff @(posedge observer_clk) begin
      if (read_select < 4'(la_pkg::num_channels)) begin
         channel_word <= shift_reg[read_select];
      end else begin
         channel_word <= bad_word;
      end
   end

   // Counter stays in range for the whole capture
   count_in_range: assert property (
      @(posedge observer_clk) disable iff (reset)
      capturing |-> (shift_count <= last_count)
   ) else $error("shift counter past capture depth");

endmodule

//--- src/la_host_port.sv
module la_host_port #(
   parameter int capture_depth = 32
) (
   input  logic                     observer_clk,
   input  logic                     reset,
   input  la_pkg::reg_req_t         reg_req,
   input  logic [capture_depth-1:0] channel_word,
   input  logic                     capturing,
   output la_pkg::la_config_t       la_config,
   output logic [7:0]               reg_datao
);

   localparam int word_bytes = capture_depth / 8;

   // Depth as reported to the host
   localparam logic [15:0] depth_code = 16'(capture_depth);

   logic [7:0] word_byte;     // Byte of channel_word picked by bytecnt
   logic [7:0] read_byte;

   // Low or high byte of a 16-bit constant and zero past the end
   function automatic logic [7:0] byte_of16(
      input logic [15:0]                      word,
      input logic [la_pkg::bytecnt_width-1:0] bytecnt
   );
      logic [7:0] result;
      case (bytecnt)
         0:       result = word[7:0];
         1:       result = word[15:8];
         default: result = 8'h00;
      endcase
      return result;
   endfunction

   // Configuration register writes
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         la_config <= '0;
      end else if (reg_req.write) begin
         case (reg_req.address)
            la_pkg::addr_trigger_source:
               la_config.trigger_source <= la_pkg::trig_t'(reg_req.datai[2:0]);
            la_pkg::addr_capture_group:
               la_config.capture_group <= la_pkg::group_t'(reg_req.datai[1:0]);
            la_pkg::addr_read_select:
               la_config.read_select <= reg_req.datai[3:0];
            default: ;   // Read-only or unknown address
         endcase
      end
   end

   // Byte of the captured word
   always_comb begin
      word_byte = 8'h00;
      if (int'(reg_req.bytecnt) < word_bytes) begin
         word_byte = channel_word[reg_req.bytecnt*8 +: 8];
      end
   end

   // Register read mux
   always_comb begin
      case (reg_req.address)
         la_pkg::addr_read_select:
            read_byte = word_byte;
         la_pkg::addr_capture_group:
            read_byte = {6'b0, la_config.capture_group};
         la_pkg::addr_status:
            read_byte = {7'b0, capturing};
         la_pkg::addr_trigger_source:
            read_byte = {5'b0, la_config.trigger_source};
         la_pkg::addr_exists:
            read_byte = byte_of16(la_pkg::exists_code, reg_req.bytecnt);
         la_pkg::addr_capture_depth:
            read_byte = byte_of16(depth_code, reg_req.bytecnt);
         default:
            read_byte = 8'h00;
      endcase
   end

   assign reg_datao = reg_req.read ? read_byte : 8'h00;   // Idle bus reads zero

   // Host never reads and writes in the same cycle
   no_read_write: assert property (
      @(posedge observer_clk) disable iff (reset)
      !(reg_req.read && reg_req.write)
   ) else $error("register read and write together");

endmodule

//--- src/la_pkg.sv
package la_pkg;

   // Capture channel count and host byte counter width
   localparam int num_channels  = 9;
   localparam int bytecnt_width = 7;

   // Register map
   localparam logic [7:0] addr_read_select    = 8'h00;
   localparam logic [7:0] addr_capture_group  = 8'h01;
   localparam logic [7:0] addr_status         = 8'h02;
   localparam logic [7:0] addr_trigger_source = 8'h03;
   localparam logic [7:0] addr_exists         = 8'h04;
   localparam logic [7:0] addr_capture_depth  = 8'h05;

   localparam logic [15:0] exists_code = 16'h4C41;   // "LA"

   // Returned for a channel select past the last channel
   localparam logic [31:0] bad_select_pattern = 32'h000F_FFFC;

   // Codes 3 to 7 never fire
   typedef enum logic [2:0] {
      trig_external = 3'd0,   // trig_in
      trig_io       = 3'd1,   // io probe bit 4
      trig_debug    = 3'd2    // debug probe bit 0
   } trig_t;

   typedef enum logic [1:0] {
      group_io      = 2'd0,
      group_user    = 2'd1,
      group_debug   = 2'd2,
      group_pattern = 2'd3    // Fixed alternating pattern
   } group_t;

   // One bit per channel with bit 0 for channel 0
   typedef logic [num_channels-1:0] sample_t;

   typedef struct packed {
      sample_t io;
      sample_t user;
      sample_t debug;
   } probe_bus_t;

   typedef struct packed {
      trig_t      trigger_source;
      group_t     capture_group;
      logic [3:0] read_select;
   } la_config_t;

   // Host register request
   typedef struct packed {
      logic [7:0]               address;
      logic [bytecnt_width-1:0] bytecnt;
      logic [7:0]               datai;
      logic                     read;
      logic                     write;
   } reg_req_t;

endpackage

//--- src/la_trigger_sampler.sv
module la_trigger_sampler (
   input  logic                  observer_clk,
   input  logic                  reset,
   input  la_pkg::la_config_t    la_config,
   input  logic                  trig_in,
   input  la_pkg::probe_bus_t    probes,
   output la_pkg::sample_t       sample,
   output logic                  capture_go
);

   // Channel 0 high and alternating upward
   localparam la_pkg::sample_t pattern_word = 9'b1_0101_0101;

   logic            trig_level;     // Selected trigger before synchronization
   logic [1:0]      trig_sync;      // Two-flop synchronizer
   logic [1:0]      trig_edge;      // Edge detector stages
   la_pkg::sample_t group_bits;     // Selected probe group, unregistered

   // Trigger source select
   always_comb begin
      case (la_config.trigger_source)
         la_pkg::trig_external: trig_level = trig_in;
         la_pkg::trig_io:       trig_level = probes.io[4];
         la_pkg::trig_debug:    trig_level = probes.debug[0];
         default:               trig_level = 1'b0;   // Unused codes never trigger
      endcase
   end

   // Synchronizer, edge detect and go pulse
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_sync  <= '0;
         trig_edge  <= '0;
         capture_go <= 1'b0;
      end else begin
         trig_sync  <= {trig_sync[0], trig_level};
         trig_edge  <= {trig_edge[0], trig_sync[1]};
         capture_go <= trig_edge[0] & ~trig_edge[1];   // Rising edge only
      end
   end

   // Probe group select
   always_comb begin
      case (la_config.capture_group)
         la_pkg::group_io:    group_bits = probes.io;
         la_pkg::group_user:  group_bits = probes.user;
         la_pkg::group_debug: group_bits = probes.debug;
         default:             group_bits = pattern_word;
      endcase
   end

   // Sample lags the probe lines by one cycle
   always_ff @(posedge observer_clk) begin
      sample <= group_bits;
   end

   // A level held high must not retrigger
   go_single_pulse: assert property (
      @(posedge observer_clk) disable iff (reset)
      capture_go |=> !capture_go
   ) else $error("capture_go high for two cycles");

endmodule

//--- src/logic_analyzer.sv
module logic_analyzer #(
   parameter int capture_depth = 32   // Multiple of 8, 8 to 1024
) (
   input  logic               observer_clk,
   input  logic               reset,
   input  la_pkg::reg_req_t   reg_req,
   output logic [7:0]         reg_datao,
   input  logic               trig_in,
   input  la_pkg::probe_bus_t probes
);

   la_pkg::la_config_t       la_config;
   la_pkg::sample_t          sample;
   logic                     capture_go;
   logic                     capturing;
   logic [capture_depth-1:0] channel_word;

   // Registers and read data
   la_host_port #(
      .capture_depth (capture_depth)
   ) host_port_inst (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .reg_req       (reg_req),
      .channel_word  (channel_word),
      .capturing     (capturing),
      .la_config     (la_config),
      .reg_datao     (reg_datao)
   );

   // Trigger path and probe sampling
   la_trigger_sampler trigger_sampler_inst (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .la_config     (la_config),
      .trig_in       (trig_in),
      .probes        (probes),
      .sample        (sample),
      .capture_go    (capture_go)
   );

   // Channel shift registers
   la_capture_buffer #(
      .capture_depth (capture_depth)
   ) capture_buffer_inst (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .read_select   (la_config.read_select),
      .sample        (sample),
      .capture_go    (capture_go),
      .capturing     (capturing),
      .channel_word  (channel_word)
   );

endmodule

//--- verif/tb_logic_analyzer.sv
module tb_logic_analyzer;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int capture_depth   = 32;
   localparam int num_entries     = 14;
   localparam int watchdog_cycles = num_entries * 200 + 100;
   localparam int poll_limit      = capture_depth + 40;   // Status polls per capture

   localparam la_pkg::reg_req_t idle_req = '0;

   // One row of the stimulus table
   typedef struct packed {
      la_pkg::trig_t  trig_source;
      la_pkg::group_t group;
      logic           toggle;       // Selected channel toggles every cycle
      logic [3:0]     channel;
      logic           from_level;   // Expected word follows the probe level
      logic [31:0]    exp_word;
   } entry_t;

   logic               observer_clk;
   logic               reset;
   la_pkg::reg_req_t   reg_req;
   logic [7:0]         reg_datao;
   logic               trig_in;
   la_pkg::probe_bus_t probes       = '0;
   la_pkg::probe_bus_t probe_base   = '0;   // Levels held on the probe lines
   la_pkg::probe_bus_t toggle_mask  = '0;   // Lines that toggle
   logic               toggle_phase = 1'b0;
   logic [15:0]        lfsr_state   = 16'd13;
   entry_t             stim_table [num_entries];

   logic_analyzer #(
      .capture_depth (capture_depth)
   ) logic_analyzer_inst (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .reg_req       (reg_req),
      .reg_datao     (reg_datao),
      .trig_in       (trig_in),
      .probes        (probes)
   );

   initial begin
      observer_clk = 1'b0;
      forever #2 observer_clk = ~observer_clk;
   end

   // Masked probe lines flip on every other edge
   always @(posedge observer_clk) begin
      toggle_phase <= ~toggle_phase;
      probes       <= toggle_phase ? (probe_base ^ toggle_mask) : probe_base;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic feedback;
      feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
      return {state[14:0], feedback};
   endfunction

   task automatic random_probes(output la_pkg::probe_bus_t levels);
      logic [$bits(la_pkg::probe_bus_t)-1:0] bits;
      for (int i = 0; i < $bits(la_pkg::probe_bus_t); i++) begin
         bits[i]    = lfsr_state[0];   // One step per bit
         lfsr_state = lfsr_next(lfsr_state);
      end
      levels = bits;
   endtask

   function automatic entry_t make_entry(
      input la_pkg::trig_t  trig_source,
      input la_pkg::group_t group,
      input logic           toggle,
      input logic [3:0]     channel,
      input logic           from_level,
      input logic [31:0]    exp_word
   );
      entry_t entry;
      entry.trig_source = trig_source;
      entry.group       = group;
      entry.toggle      = toggle;
      entry.channel     = channel;
      entry.from_level  = from_level;
      entry.exp_word    = exp_word;
      return entry;
   endfunction

   task automatic load_table();
      // Constant levels on each group and from all three trigger sources
      stim_table[0]  = make_entry(la_pkg::trig_external, la_pkg::group_io, 0, 4'd2, 1, 32'h0);
      stim_table[1]  = make_entry(la_pkg::trig_io, la_pkg::group_io, 0, 4'd4, 1, 32'h0);
      stim_table[2]  = make_entry(la_pkg::trig_debug, la_pkg::group_user, 0, 4'd7, 1, 32'h0);
      stim_table[3]  = make_entry(la_pkg::trig_external, la_pkg::group_debug, 0, 4'd0, 1, 32'h0);
      stim_table[4]  = make_entry(la_pkg::trig_io, la_pkg::group_debug, 0, 4'd5, 1, 32'h0);
      stim_table[5]  = make_entry(la_pkg::trig_debug, la_pkg::group_debug, 0, 4'd0, 1, 32'h0);
      stim_table[6]  = make_entry(la_pkg::trig_external, la_pkg::group_user, 0, 4'd8, 1, 32'h0);
      // Fixed pattern with even channels high
      stim_table[7]  = make_entry(la_pkg::trig_external, la_pkg::group_pattern, 0, 4'd0, 0,
                                  32'hFFFF_FFFF);
      stim_table[8]  = make_entry(la_pkg::trig_io, la_pkg::group_pattern, 0, 4'd3, 0, 32'h0);
      stim_table[9]  = make_entry(la_pkg::trig_external, la_pkg::group_pattern, 0, 4'd8, 0,
                                  32'hFFFF_FFFF);
      stim_table[10] = make_entry(la_pkg::trig_external, la_pkg::group_io, 1, 4'd1, 0,
                                  32'h5555_5555);
      stim_table[11] = make_entry(la_pkg::trig_debug, la_pkg::group_user, 1, 4'd6, 0,
                                  32'h5555_5555);
      // Channel select past the last channel
      stim_table[12] = make_entry(la_pkg::trig_external, la_pkg::group_io, 0, 4'd9, 0,
                                  32'h000F_FFFC);
      stim_table[13] = make_entry(la_pkg::trig_external, la_pkg::group_user, 0, 4'd15, 0,
                                  32'h000F_FFFC);
   endtask

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_value(
      input string       name,
      input logic [31:0] actual,
      input logic [31:0] expected
   );
      if (actual !== expected) begin
         $display("error at %0t: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
         fail_run("value mismatch");
      end
   endtask

   task automatic wait_cycles(input int cycles);
      repeat (cycles) @(posedge observer_clk);
   endtask

   task automatic write_reg(input logic [7:0] address, input logic [7:0] data);
      @(posedge observer_clk);
      reg_req <= '{address: address, bytecnt: '0, datai: data, read: 1'b0, write: 1'b1};
      @(posedge observer_clk);
      reg_req <= idle_req;
   endtask

   // Read data sampled at the falling edge
   task automatic read_reg(
      input  logic [7:0] address,
      input  int         byte_index,
      output logic [7:0] data
   );
      @(posedge observer_clk);
      reg_req <= '{address: address, bytecnt: la_pkg::bytecnt_width'(byte_index),
                   datai: 8'h00, read: 1'b1, write: 1'b0};
      @(negedge observer_clk);
      data = reg_datao;
   endtask

   task automatic read_and_check(
      input string      name,
      input logic [7:0] address,
      input int         byte_index,
      input logic [7:0] expected
   );
      logic [7:0] data;
      read_reg(address, byte_index, data);
      check_value(name, 32'(data), 32'(expected));
   endtask

   // Status bit has to rise and then fall again
   task automatic wait_capture_done();
      logic [7:0] status;
      logic       seen_rise;
      logic       done;
      int         polls;
      seen_rise = 1'b0;
      done      = 1'b0;
      polls     = 0;
      while (!done) begin
         read_reg(la_pkg::addr_status, 0, status);
         if (status[0]) begin
            seen_rise = 1'b1;
         end else if (seen_rise) begin
            done = 1'b1;
         end
         polls++;
         if (!done && polls >= poll_limit) begin
            fail_run("the capture never finished within the poll limit");
         end
      end
   endtask

   // All ones or all zeros from the probe level of the channel
   function automatic logic [31:0] level_word(
      input la_pkg::probe_bus_t levels,
      input la_pkg::group_t     group,
      input logic [3:0]         channel
   );
      logic level;
      case (group)
         la_pkg::group_io:    level = levels.io[channel];
         la_pkg::group_user:  level = levels.user[channel];
         la_pkg::group_debug: level = levels.debug[channel];
         default:             level = 1'b0;
      endcase
      return level ? 32'hFFFF_FFFF : 32'h0000_0000;
   endfunction

   initial begin : watchdog
      repeat (watchdog_cycles) @(posedge observer_clk);
      fail_run("watchdog timeout, the tests did not finish in time");
   end

   initial begin : main_seq
      entry_t             entry;
      la_pkg::probe_bus_t levels;
      la_pkg::probe_bus_t mask;
      logic [7:0]         data;
      logic [31:0]        word;
      logic [31:0]        expected;

      reset   = 1'b1;
      trig_in = 1'b0;
      reg_req = idle_req;
      load_table();
      wait_cycles(4);
      reset <= 1'b0;

      // Identity, depth and reset values
      read_and_check("exists byte 0", la_pkg::addr_exists, 0, 8'h41);
      read_and_check("exists byte 1", la_pkg::addr_exists, 1, 8'h4C);
      read_and_check("depth byte 0", la_pkg::addr_capture_depth, 0, 8'd32);
      read_and_check("depth byte 1", la_pkg::addr_capture_depth, 1, 8'd0);
      read_and_check("status", la_pkg::addr_status, 0, 8'h00);
      read_and_check("trigger_source", la_pkg::addr_trigger_source, 0, 8'h00);
      read_and_check("capture_group", la_pkg::addr_capture_group, 0, 8'h00);
      read_and_check("channel 0 byte 0", la_pkg::addr_read_select, 0, 8'h00);
      read_and_check("unknown address", 8'h77, 0, 8'h00);

      // Writes are masked to the field width
      write_reg(la_pkg::addr_trigger_source, 8'hFD);
      write_reg(la_pkg::addr_capture_group, 8'hFE);
      write_reg(la_pkg::addr_read_select, 8'hFC);   // Select 12
      wait_cycles(2);
      read_and_check("trigger_source", la_pkg::addr_trigger_source, 0, 8'h05);
      read_and_check("capture_group", la_pkg::addr_capture_group, 0, 8'h02);
      read_and_check("bad select byte 0", la_pkg::addr_read_select, 0, 8'hFC);
      read_and_check("bad select byte 1", la_pkg::addr_read_select, 1, 8'hFF);
      write_reg(la_pkg::addr_trigger_source, 8'h00);
      write_reg(la_pkg::addr_capture_group, 8'h00);

      for (int i = 0; i < num_entries; i++) begin
         entry = stim_table[i];
         random_probes(levels);
         case (entry.trig_source)   // Selected trigger line starts low
            la_pkg::trig_io:    levels.io[4]    = 1'b0;
            la_pkg::trig_debug: levels.debug[0] = 1'b0;
            default: ;
         endcase
         mask = '0;
         if (entry.toggle) begin
            case (entry.group)
               la_pkg::group_io:    mask.io[entry.channel]    = 1'b1;
               la_pkg::group_user:  mask.user[entry.channel]  = 1'b1;
               la_pkg::group_debug: mask.debug[entry.channel] = 1'b1;
               default: ;
            endcase
         end
         @(posedge observer_clk);
         trig_in     <= 1'b0;
         probe_base  <= levels;
         toggle_mask <= mask;
         wait_cycles(6);   // Let the synchronizer see the low level
         write_reg(la_pkg::addr_trigger_source, {5'b0, entry.trig_source});
         write_reg(la_pkg::addr_capture_group, {6'b0, entry.group});
         wait_cycles(2);

         // Raise the trigger and keep it high
         case (entry.trig_source)
            la_pkg::trig_io:    levels.io[4]    = 1'b1;
            la_pkg::trig_debug: levels.debug[0] = 1'b1;
            default: ;
         endcase
         @(posedge observer_clk);
         if (entry.trig_source == la_pkg::trig_external) begin
            trig_in <= 1'b1;
         end
         probe_base <= levels;
         wait_capture_done();

         write_reg(la_pkg::addr_read_select, {4'b0, entry.channel});
         wait_cycles(2);
         for (int b = 0; b < 4; b++) begin
            read_reg(la_pkg::addr_read_select, b, data);
            word[8*b +: 8] = data;
         end
         if (entry.toggle) begin
            // Phase depends on the trigger alignment
            expected = (word == 32'hAAAA_AAAA) ? 32'hAAAA_AAAA : 32'h5555_5555;
         end else if (entry.from_level) begin
            expected = level_word(levels, entry.group, entry.channel);
         end else begin
            expected = entry.exp_word;
         end
         check_value("channel_word", word, expected);
      end

      // Trigger codes 3 to 7 never start a capture
      @(posedge observer_clk);
      trig_in     <= 1'b0;
      probe_base  <= '0;
      toggle_mask <= '0;
      wait_cycles(6);
      for (int code = 3; code < 8; code++) begin
         write_reg(la_pkg::addr_trigger_source, 8'(code));
         levels          = '0;
         levels.io[4]    = 1'b1;
         levels.debug[0] = 1'b1;
         @(posedge observer_clk);
         trig_in    <= 1'b1;
         probe_base <= levels;
         for (int n = 0; n < 50; n++) begin
            read_reg(la_pkg::addr_status, 0, data);
            check_value("capturing", 32'(data[0]), 32'h0);
         end
         @(posedge observer_clk);
         trig_in    <= 1'b0;
         probe_base <= '0;
         wait_cycles(6);
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
